/* raster_core.f */
src/raster_pkg.sv
src/scene_ram.sv
src/spi_loader.sv
src/frame_driver.sv
src/vertex_lane.sv
src/tri_assembler.sv
src/raster_top.sv
dv/tb_raster_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_raster_top
FILELIST   := raster_core.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP)
LOG        := sim.log
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_raster_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_raster_top
    import raster_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RST_CYCLES   = 5;
    localparam int DRAW_TIMEOUT = 3000;
    localparam int BUSY_TIMEOUT = 50;
    localparam int QUIET_CYCLES = 20;
    localparam int NUM_CMD      = 30;
    localparam int NUM_READY    = 3;

    // One host command, abort_at counts nibbles sent before CS_n rises (0 = whole command)
    typedef struct packed {
        logic [3:0]  op;
        logic [7:0]  addr;
        logic [71:0] data;
        logic [4:0]  abort_at;
        logic [1:0]  ready_sel;
        logic        resend;
    } cmd_t;

    // Ready modes: 0 always high, 1 random, 2 low for hold cycles then high
    typedef struct packed {
        logic [1:0] mode;
        logic [7:0] hold;
    } ready_pat_t;

    logic       clk;
    logic       rst;
    logic       sck;
    logic       CS_n;
    logic [3:0] mosi;
    logic       miso;
    logic       draw_ready;
    logic       draw_valid;
    logic       draw_done;
    triangle_t  tri_out;

    integer     seed;
    vertex_t    vert_model [MAX_VERT];
    tri_idx_t   tri_model [MAX_TRI];
    inst_t      inst_model [MAX_INST];
    triangle_t  exp_q [$];

    // ==================================================
    // Stimulus tables
    // ==================================================
    cmd_t cmd_tab [NUM_CMD] = '{
        // Vertex store
        '{OP_VERT, 8'd0, 72'h0010_0020_0030, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd1, 72'hFFF8_0100_0200, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd2, 72'h1000_2000_3000, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd3, 72'h0001_0002_0003, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd4, 72'h7FFF_8000_FFFF, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd5, 72'h0A0A_0B0B_0C0C, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd6, 72'h1234_5678_9ABC, 5'd0, 2'd0, 1'b0},
        '{OP_VERT, 8'd7, 72'hFEDC_BA98_7654, 5'd0, 2'd0, 1'b0},
        // Triangle store, i0 i1 i2
        '{OP_TRI, 8'd0, 72'h00_01_02, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd1, 72'h01_02_03, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd2, 72'h02_03_04, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd3, 72'h03_04_05, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd4, 72'h04_05_00, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd5, 72'h05_00_01, 5'd0, 2'd0, 1'b0},
        '{OP_TRI, 8'd6, 72'h00_02_04, 5'd0, 2'd0, 1'b0},
        // Instances: vert_base, tri_base, tri_count, translation
        '{OP_INST, 8'd0, {8'd0, 8'd0, 8'd1, 16'h0010, 16'h0001, 16'hFFFF}, 5'd0, 2'd0, 1'b0},
        '{OP_INST, 8'd1, {8'd0, 8'd1, 8'd6, 16'h0100, 16'h0200, 16'h0300}, 5'd0, 2'd0, 1'b0},
        '{OP_INST, 8'd2, {8'd2, 8'd1, 8'd3, 16'h8000, 16'h0000, 16'h0001}, 5'd0, 2'd0, 1'b0},
        '{OP_INST, 8'd3, {8'd1, 8'd4, 8'd2, 16'hFFFF, 16'hFFFF, 16'hFFFF}, 5'd0, 2'd0, 1'b0},
        '{OP_INST, 8'd4, {8'd3, 8'd0, 8'd0, 16'h0000, 16'h0000, 16'h0000}, 5'd0, 2'd0, 1'b0},
        // Draws
        '{OP_DRAW, 8'd0, 72'h0, 5'd0, 2'd0, 1'b0},
        '{OP_DRAW, 8'd1, 72'h0, 5'd0, 2'd1, 1'b0},
        '{OP_DRAW, 8'd2, 72'h0, 5'd0, 2'd0, 1'b0},
        '{OP_DRAW, 8'd3, 72'h0, 5'd0, 2'd1, 1'b0},
        '{OP_DRAW, 8'd1, 72'h0, 5'd0, 2'd2, 1'b1},
        '{OP_DRAW, 8'd4, 72'h0, 5'd0, 2'd0, 1'b0},
        // Aborted vertex write, unknown opcode, aborted instance write
        '{OP_VERT, 8'd1, 72'h0000_0000_0000, 5'd8, 2'd0, 1'b0},
        '{4'hA, 8'd0, 72'h1111_2222_3333, 5'd0, 2'd0, 1'b0},
        '{OP_INST, 8'd0, {8'd5, 8'd5, 8'd3, 16'h0000, 16'h0000, 16'h0000}, 5'd10, 2'd0, 1'b0},
        '{OP_DRAW, 8'd0, 72'h0, 5'd0, 2'd1, 1'b0}
    };

    ready_pat_t ready_tab [NUM_READY] = '{
        '{2'd0, 8'd0},
        '{2'd1, 8'd0},
        '{2'd2, 8'd40}
    };

    raster_top UUT (
        .clk(clk),
        .rst(rst),
        .sck(sck),
        .CS_n(CS_n),
        .mosi(mosi),
        .miso(miso),
        .draw_ready(draw_ready),
        .draw_valid(draw_valid),
        .draw_done(draw_done),
        .tri_out(tri_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [143:0] got,
                               input logic [143:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("[FAIL] t=%0t %s: got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    // One nibble, sck low for 2 clk then high for 2 clk
    task automatic spi_nibble(input logic [3:0] nib);
        sck  = 1'b0;
        mosi = nib;
        repeat (2) @(negedge clk);
        sck = 1'b1;
        repeat (2) @(negedge clk);
    endtask

    task automatic update_model(input cmd_t c);
        case (c.op)
            OP_VERT: vert_model[c.addr] = c.data[47:0];
            OP_TRI:  tri_model[c.addr] = c.data[23:0];
            OP_INST: inst_model[c.addr[3:0]] = c.data;
            default: ;
        endcase
    endtask

    task automatic send_cmd(input cmd_t c);
        logic [79:0] bits;
        int          n;
        int          sent;
        case (c.op)
            OP_TRI: begin
                bits = {44'd0, c.op, c.addr, c.data[23:0]};
                n    = 9;
            end
            OP_INST: begin
                bits = {c.op, c.addr[3:0], c.data};
                n    = 20;
            end
            OP_DRAW: begin
                bits = {72'd0, c.op, c.addr[3:0]};
                n    = 2;
            end
            default: begin
                // Vertex layout, also used for unknown opcodes
                bits = {20'd0, c.op, c.addr, c.data[47:0]};
                n    = 15;
            end
        endcase
        sent = (c.abort_at != '0) ? int'(c.abort_at) : n;
        // Deselected gap between commands
        sck  = 1'b0;
        CS_n = 1'b1;
        repeat (3) @(negedge clk);
        CS_n = 1'b0;
        for (int i = n - 1; i >= n - sent; i--) begin
            spi_nibble(bits[4*i +: 4]);
        end
        sck  = 1'b0;
        CS_n = 1'b1;
        if (c.abort_at == '0) begin
            update_model(c);
        end
    endtask

    function automatic vertex_t translate(input vertex_t v, input vertex_t t);
        vertex_t r;
        r.x = v.x + t.x;
        r.y = v.y + t.y;
        r.z = v.z + t.z;
        return r;
    endfunction

    // Expected triangles for one draw, in triangle-store order
    task automatic build_expected(input logic [3:0] id);
        inst_t      rec;
        tri_idx_t   idx;
        triangle_t  t;
        logic [7:0] tp;
        exp_q.delete();
        rec = inst_model[id];
        for (int k = 0; k < int'(rec.tri_count); k++) begin
            tp   = rec.tri_base + 8'(k);
            idx  = tri_model[tp];
            t.v0 = translate(vert_model[8'(rec.vert_base + idx.i0)], rec.trans);
            t.v1 = translate(vert_model[8'(rec.vert_base + idx.i1)], rec.trans);
            t.v2 = translate(vert_model[8'(rec.vert_base + idx.i2)], rec.trans);
            exp_q.push_back(t);
        end
    endtask

    task automatic pick_ready(input ready_pat_t p, input int cyc, output logic rdy);
        logic [31:0] rand_word;
        case (p.mode)
            2'd1: begin
                rand_word = $random(seed);
                rdy       = rand_word[0];
            end
            2'd2:    rdy = (cyc > int'(p.hold));
            default: rdy = 1'b1;
        endcase
    endtask

    // Second draw command sent while the first one is still running
    task automatic resend_while_busy(input cmd_t c);
        int wait_cyc;
        wait_cyc = 0;
        while (miso !== 1'b1) begin
            @(negedge clk);
            wait_cyc++;
            if (wait_cyc > BUSY_TIMEOUT) begin
                fail_now("Timeout: miso never went high after a draw command");
            end
        end
        send_cmd(c);
        check_value("miso", miso, 1'b1);
    endtask

    // ==================================================
    // Downstream monitor for one draw
    // ==================================================
    task automatic watch_draw(input ready_pat_t p);
        int        cyc;
        int        got;
        int        quiet;
        logic      done_seen;
        logic      last_prev;
        logic      stall_prev;
        logic      rdy;
        triangle_t held;
        cyc        = 0;
        got        = 0;
        quiet      = 0;
        done_seen  = 1'b0;
        last_prev  = 1'b0;
        stall_prev = 1'b0;
        held       = '0;
        while (!done_seen || quiet < QUIET_CYCLES) begin
            @(negedge clk);
            cyc++;
            if (cyc > DRAW_TIMEOUT) begin
                fail_now("Timeout: draw did not finish within the cycle limit");
            end
            // Stalled head must not move
            if (stall_prev) begin
                check_value("draw_valid", draw_valid, 1'b1);
                check_value("tri_out", tri_out, held);
            end
            if (draw_done || last_prev) begin
                check_value("draw_done", draw_done, 1'b1);
                check_value("draw_done repeat", done_seen, 1'b0);
                check_value("triangle count", got, exp_q.size());
                done_seen = 1'b1;
            end
            if (done_seen) begin
                quiet++;
                check_value("draw_valid after done", draw_valid, 1'b0);
            end
            pick_ready(p, cyc, rdy);
            draw_ready = rdy;
            last_prev  = 1'b0;
            stall_prev = draw_valid && !rdy;
            held       = tri_out;
            if (draw_valid && rdy) begin
                check_value("triangle within count", got < exp_q.size(), 1'b1);
                check_value($sformatf("tri_out[%0d]", got), tri_out, exp_q[got]);
                got++;
                last_prev = (got == exp_q.size());
            end
        end
        draw_ready = 1'b0;
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        seed       = 51966;
        rst        = 1'b1;
        sck        = 1'b0;
        CS_n       = 1'b1;
        mosi       = 4'h0;
        draw_ready = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        check_value("miso", miso, 1'b0);
        for (int i = 0; i < NUM_CMD; i++) begin
            send_cmd(cmd_tab[i]);
            if (cmd_tab[i].op == OP_DRAW && cmd_tab[i].abort_at == '0) begin
                build_expected(cmd_tab[i].addr[3:0]);
                if (cmd_tab[i].resend) begin
                    resend_while_busy(cmd_tab[i]);
                end
                watch_draw(ready_tab[cmd_tab[i].ready_sel]);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/raster_top.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_top
    import raster_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sck,
    input  logic       CS_n,
    input  logic [3:0] mosi,
    output logic       miso,
    input  logic       draw_ready,
    output logic       draw_valid,
    output logic       draw_done,
    output triangle_t  tri_out
);

    // ==================================================
    // Internal signals
    // ==================================================

    // Loader to stores and driver
    logic                   busy;
    logic [VIDX_W-1:0]      wr_addr;
    logic                   vert_we;
    vertex_t                vert_wdata;
    logic                   tri_we;
    tri_idx_t               tri_wdata;
    logic                   inst_we;
    inst_t                  inst_wdata;
    logic                   draw_start;
    logic [IID_W-1:0]       draw_inst;

    // Driver and stores
    logic [IID_W-1:0]       inst_raddr;
    inst_t                  inst_rdata;
    logic [TIDX_W-1:0]      tri_raddr;
    tri_idx_t               tri_rdata;

    // Issue and drain paths
    logic                   issue_valid;
    logic [2:0][VIDX_W-1:0] lane_addr;
    vertex_t                offset;
    logic                   last_issue;
    logic [2:0]             vtx_valid;
    vertex_t [2:0]          vtx;
    logic                   room;
    logic                   drain_done;

    spi_loader u_spi_loader (
        .clk(clk),
        .rst(rst),
        .sck(sck),
        .CS_n(CS_n),
        .mosi(mosi),
        .busy(busy),
        .miso(miso),
        .wr_addr(wr_addr),
        .vert_we(vert_we),
        .vert_wdata(vert_wdata),
        .tri_we(tri_we),
        .tri_wdata(tri_wdata),
        .inst_we(inst_we),
        .inst_wdata(inst_wdata),
        .draw_start(draw_start),
        .draw_inst(draw_inst)
    );

    // Instance and triangle stores
    scene_ram #(
        .entry_t(inst_t),
        .DEPTH(MAX_INST)
    ) u_inst_ram (
        .clk(clk),
        .we(inst_we),
        .waddr(wr_addr[IID_W-1:0]),
        .wdata(inst_wdata),
        .raddr(inst_raddr),
        .rdata(inst_rdata)
    );

    scene_ram #(
        .entry_t(tri_idx_t),
        .DEPTH(MAX_TRI)
    ) u_tri_ram (
        .clk(clk),
        .we(tri_we),
        .waddr(wr_addr),
        .wdata(tri_wdata),
        .raddr(tri_raddr),
        .rdata(tri_rdata)
    );

    frame_driver u_frame_driver (
        .clk(clk),
        .rst(rst),
        .draw_start(draw_start),
        .draw_inst(draw_inst),
        .inst_raddr(inst_raddr),
        .inst_rdata(inst_rdata),
        .tri_raddr(tri_raddr),
        .tri_rdata(tri_rdata),
        .room(room),
        .drain_done(drain_done),
        .busy(busy),
        .issue_valid(issue_valid),
        .lane_addr(lane_addr),
        .offset(offset),
        .last_issue(last_issue)
    );

    // One lane per corner, all share the vertex writes
    for (genvar i = 0; i < 3; i++) begin : g_lane
        vertex_lane u_lane (
            .clk(clk),
            .rst(rst),
            .we(vert_we),
            .waddr(wr_addr),
            .wdata(vert_wdata),
            .issue_valid(issue_valid),
            .raddr(lane_addr[i]),
            .offset(offset),
            .vtx_valid(vtx_valid[i]),
            .vtx(vtx[i])
        );
    end

    tri_assembler u_tri_assembler (
        .clk(clk),
        .rst(rst),
        .vtx_valid(vtx_valid),
        .vtx(vtx),
        .last_issue(last_issue),
        .room(room),
        .drain_done(drain_done),
        .draw_ready(draw_ready),
        .draw_valid(draw_valid),
        .tri_out(tri_out),
        .draw_done(draw_done)
    );

endmodule

`default_nettype wire

/* src/tri_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module tri_assembler
    import raster_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic [2:0]    vtx_valid,
    input  vertex_t [2:0] vtx,
    input  logic          last_issue,
    output logic          room,
    output logic          drain_done,
    input  logic          draw_ready,
    output logic          draw_valid,
    output triangle_t     tri_out,
    output logic          draw_done
);

    triangle_t  fifo_q [4];
    logic [3:0] last_q;
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] fill;
    logic       push;
    logic       pop;

    assign push = vtx_valid[0];
    assign pop  = draw_valid && draw_ready;

    // ==================================================
    // Four-entry triangle FIFO
    // ==================================================
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[wr_ptr] <= '{v0: vtx[0], v1: vtx[1], v2: vtx[2]};
            last_q[wr_ptr] <= last_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            draw_done <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // Last triangle accepted, or an empty draw
            draw_done <= (pop && last_q[rd_ptr]) || (last_issue && !push);
        end
    end

    // Head entry stays put until the downstream takes it
    assign draw_valid = (fill != '0);
    assign tri_out    = fifo_q[rd_ptr];

    // Two more triangles may already be on their way
    assign room       = (fill <= 3'd1);
    assign drain_done = draw_done;

    // Lanes run in lockstep
    assert property (@(posedge clk) disable iff (rst)
        (vtx_valid == 3'b000) || (vtx_valid == 3'b111))
        else $error("tri_assembler lane valids disagree: %b", vtx_valid);

    assert property (@(posedge clk) disable iff (rst) push |-> (fill != 3'd4))
        else $error("tri_assembler push into a full FIFO");

endmodule

`default_nettype wire

/* src/vertex_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module vertex_lane
    import raster_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  logic [VIDX_W-1:0] waddr,
    input  vertex_t           wdata,
    input  logic              issue_valid,
    input  logic [VIDX_W-1:0] raddr,
    input  vertex_t           offset,
    output logic              vtx_valid,
    output vertex_t           vtx
);

    vertex_t vert_q;
    vertex_t offset_q;

    // Private copy of the vertex store
    scene_ram #(
        .entry_t(vertex_t),
        .DEPTH(MAX_VERT)
    ) u_vert_ram (
        .clk(clk),
        .we(we),
        .waddr(waddr),
        .wdata(wdata),
        .raddr(raddr),
        .rdata(vert_q)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            vtx_valid <= 1'b0;
        end else begin
            vtx_valid <= issue_valid;
        end
    end

    // Offset travels alongside the read
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            offset_q <= offset;
        end
    end

    // Translation, each coordinate wraps at COORD_W
    assign vtx.x = vert_q.x + offset_q.x;
    assign vtx.y = vert_q.y + offset_q.y;
    assign vtx.z = vert_q.z + offset_q.z;

endmodule

`default_nettype wire

/* src/frame_driver.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_driver
    import raster_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   draw_start,
    input  logic [IID_W-1:0]       draw_inst,
    output logic [IID_W-1:0]       inst_raddr,
    input  inst_t                  inst_rdata,
    output logic [TIDX_W-1:0]      tri_raddr,
    input  tri_idx_t               tri_rdata,
    input  logic                   room,
    input  logic                   drain_done,
    output logic                   busy,
    output logic                   issue_valid,
    output logic [2:0][VIDX_W-1:0] lane_addr,
    output vertex_t                offset,
    output logic                   last_issue
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_INST,
        S_WALK,
        S_DRAIN
    } state_t;

    state_t             state;
    logic [VIDX_W-1:0]  vert_base;
    logic [TIDX_W-1:0]  tri_ptr;
    logic [TIDX_W-1:0]  remain;
    logic               last_rd;
    logic               rd_go;

    // Instance store is read every cycle, valid in S_INST
    assign inst_raddr = draw_inst;
    assign tri_raddr  = tri_ptr;

    // Next triangle read, throttled by the assembler
    assign rd_go = (state == S_WALK) && room && (remain != '0);

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            remain      <= '0;
            issue_valid <= 1'b0;
            last_issue  <= 1'b0;
        end else begin
            issue_valid <= rd_go;
            // Aligned with the lane outputs, one cycle after the issue
            last_issue  <= (issue_valid && last_rd) ||
                           (state == S_INST && inst_rdata.tri_count == '0);
            case (state)
                S_IDLE: begin
                    if (draw_start) begin
                        state <= S_INST;
                    end
                end
                S_INST: begin
                    remain <= inst_rdata.tri_count;
                    if (inst_rdata.tri_count == '0) begin
                        state <= S_DRAIN;
                    end else begin
                        state <= S_WALK;
                    end
                end
                S_WALK: begin
                    if (rd_go) begin
                        remain <= remain - 1'b1;
                        if (remain == 1) begin
                            state <= S_DRAIN;
                        end
                    end
                end
                default: begin
                    if (drain_done) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Per-draw parameters and walk pointer
    always_ff @(posedge clk) begin
        if (state == S_INST) begin
            vert_base <= inst_rdata.vert_base;
            tri_ptr   <= inst_rdata.tri_base;
            offset    <= inst_rdata.trans;
        end else if (rd_go) begin
            tri_ptr   <= tri_ptr + 1'b1;
        end
        if (rd_go) begin
            last_rd <= (remain == 1);
        end
    end

    // Corner addresses come straight off the triangle store
    assign lane_addr[0] = vert_base + tri_rdata.i0;
    assign lane_addr[1] = vert_base + tri_rdata.i1;
    assign lane_addr[2] = vert_base + tri_rdata.i2;

    assign busy = (state != S_IDLE);

    // An issue always follows a read that saw room
    assert property (@(posedge clk) disable iff (rst) issue_valid |-> $past(room))
        else $error("frame_driver issued a triangle without FIFO room");

endmodule

`default_nettype wire

/* src/spi_loader.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_loader
    import raster_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              sck,
    input  logic              CS_n,
    input  logic [3:0]        mosi,
    input  logic              busy,
    output logic              miso,
    output logic [VIDX_W-1:0] wr_addr,
    output logic              vert_we,
    output vertex_t           vert_wdata,
    output logic              tri_we,
    output tri_idx_t          tri_wdata,
    output logic              inst_we,
    output inst_t             inst_wdata,
    output logic              draw_start,
    output logic [IID_W-1:0]  draw_inst
);

    // ==================================================
    // Link synchronizers and sck edge detect
    // ==================================================
    logic       sck_meta, sck_sync, sck_prev;
    logic       cs_meta, cs_sync;
    logic [3:0] mosi_meta, mosi_sync;
    logic       sck_rise;

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_meta  <= 1'b0;
            sck_sync  <= 1'b0;
            sck_prev  <= 1'b0;
            cs_meta   <= 1'b1;
            cs_sync   <= 1'b1;
            mosi_meta <= '0;
            mosi_sync <= '0;
        end else begin
            sck_meta  <= sck;
            sck_sync  <= sck_meta;
            sck_prev  <= sck_sync;
            cs_meta   <= CS_n;
            cs_sync   <= cs_meta;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
        end
    end

    assign sck_rise = sck_sync && !sck_prev;

    // ==================================================
    // Command parser
    // ==================================================
    logic               have_op;
    logic               skip;
    logic [3:0]         opcode;
    logic [4:0]         nib_cnt;
    logic [4:0]         cmd_len;
    logic               op_known;
    logic [SHIFT_W-1:0] shreg;

    always_comb begin
        op_known = mosi_sync inside {OP_VERT, OP_TRI, OP_INST, OP_DRAW};
        case (opcode)
            OP_VERT: cmd_len = 5'(LEN_VERT);
            OP_TRI:  cmd_len = 5'(LEN_TRI);
            OP_INST: cmd_len = 5'(LEN_INST);
            default: cmd_len = 5'(LEN_DRAW);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            have_op    <= 1'b0;
            skip       <= 1'b0;
            opcode     <= '0;
            nib_cnt    <= '0;
            vert_we    <= 1'b0;
            tri_we     <= 1'b0;
            inst_we    <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            vert_we    <= 1'b0;
            tri_we     <= 1'b0;
            inst_we    <= 1'b0;
            draw_start <= 1'b0;
            if (cs_sync) begin
                // Deselect drops any partial command
                have_op <= 1'b0;
                skip    <= 1'b0;
                nib_cnt <= '0;
            end else if (sck_rise && !skip) begin
                if (!have_op) begin
                    opcode  <= mosi_sync;
                    nib_cnt <= '0;
                    have_op <= op_known;
                    skip    <= !op_known;
                end else begin
                    nib_cnt <= nib_cnt + 5'd1;
                    if (nib_cnt + 5'd1 == cmd_len) begin
                        have_op    <= 1'b0;
                        vert_we    <= (opcode == OP_VERT);
                        tri_we     <= (opcode == OP_TRI);
                        inst_we    <= (opcode == OP_INST);
                        draw_start <= (opcode == OP_DRAW);
                    end
                end
            end
        end
    end

    // Payload nibbles, MSB first
    always_ff @(posedge clk) begin
        if (sck_rise && !cs_sync && have_op) begin
            shreg <= {shreg[SHIFT_W-5:0], mosi_sync};
        end
    end

    // Fields sit right-aligned in the shift register once the command ends
    always_comb begin
        case (opcode)
            OP_INST: wr_addr = VIDX_W'(shreg[SHIFT_W-1 -: IID_W]);
            OP_TRI:  wr_addr = shreg[$bits(tri_idx_t) +: VIDX_W];
            default: wr_addr = shreg[$bits(vertex_t) +: VIDX_W];
        endcase
    end

    assign vert_wdata = shreg[$bits(vertex_t)-1:0];
    assign tri_wdata  = shreg[$bits(tri_idx_t)-1:0];
    assign inst_wdata = shreg[$bits(inst_t)-1:0];
    assign draw_inst  = shreg[IID_W-1:0];

    // Host polls busy on miso
    assign miso = busy;

    // One command, one pulse
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({vert_we, tri_we, inst_we, draw_start}))
        else $error("spi_loader raised more than one command pulse");

endmodule

`default_nettype wire

/* src/scene_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module scene_ram
    import raster_pkg::*;
#(
    parameter type entry_t = vertex_t,
    parameter int  DEPTH   = MAX_VERT
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // One write port, registered read port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    // Writes from the loader stay inside the store
    assert property (@(posedge clk) we |-> (int'(waddr) < DEPTH))
        else $error("scene_ram write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

/* src/raster_pkg.sv */
`default_nettype none

package raster_pkg;

    // ==================================================
    // Scene sizes
    // ==================================================
    localparam int MAX_VERT = 256;
    localparam int VIDX_W   = 8;
    localparam int MAX_TRI  = 256;
    localparam int TIDX_W   = 8;
    localparam int MAX_INST = 16;
    localparam int IID_W    = 4;
    localparam int COORD_W  = 16;

    // Host command opcodes, first nibble of every command
    localparam logic [3:0] OP_VERT = 4'd1;
    localparam logic [3:0] OP_TRI  = 4'd2;
    localparam logic [3:0] OP_INST = 4'd3;
    localparam logic [3:0] OP_DRAW = 4'd4;

    // ==================================================
    // Payload types
    // ==================================================
    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] z;
    } vertex_t;

    typedef struct packed {
        logic [VIDX_W-1:0] i0;
        logic [VIDX_W-1:0] i1;
        logic [VIDX_W-1:0] i2;
    } tri_idx_t;

    typedef struct packed {
        logic [VIDX_W-1:0] vert_base;
        logic [TIDX_W-1:0] tri_base;
        logic [TIDX_W-1:0] tri_count;
        vertex_t           trans;
    } inst_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Payload nibbles that follow the opcode
    localparam int LEN_VERT = (VIDX_W + $bits(vertex_t)) / 4;
    localparam int LEN_TRI  = (VIDX_W + $bits(tri_idx_t)) / 4;
    localparam int LEN_INST = (IID_W + $bits(inst_t)) / 4;
    localparam int LEN_DRAW = IID_W / 4;

    // Longest command payload sets the shift register width
    localparam int SHIFT_W  = 4 * LEN_INST;

endpackage

`default_nettype wire
